//--- backEndPkg.sv
// back-end occupancy counts must be sampled in the same cycle as the bundle they are checked against
`default_nettype none

`include "dispatchDefines.svh"

package backEndPkg;

	// instruction class as decoded by rename
	// each class maps onto one kind of execution pipe
	typedef enum logic [1:0] {
		fuSimple  = 2'd0,
		fuComplex = 2'd1,
		fuMemory  = 2'd2,
		fuControl = 2'd3
	} fuClass;

	// current fill level of every back-end structure
	// a count can reach the full size, hence the extra bit on each field
	typedef struct packed {
		logic [`SIZE_ISSUEQ_LOG:0]     iqCnt;
		logic [`SIZE_ACTIVELIST_LOG:0] alCnt;
		logic [`SIZE_LSQ_LOG:0]        ldqCnt;
		logic [`SIZE_LSQ_LOG:0]        stqCnt;
	} occupancy;

	// one flag per structure that cannot take the bundle
	// the flags only ever leave the stall check OR-ed into a single stall
	typedef struct packed {
		logic iqFull;
		logic alFull;
		logic ldqFull;
		logic stqFull;
	} stallCause;

endpackage

`default_nettype wire

//--- backEndStallCheck.sv
// purely combinational, IQ and AL room is reserved for a full bundle whatever the number of valid lanes
`timescale 1ns/1ps
`default_nettype none

`include "dispatchDefines.svh"

module backEndStallCheck (
	input  wire                                      rstN_i,
	input  wire dispatchPkg::disPkt [`DISPATCH_WIDTH-1:0] bundle_i,
	input  wire backEndPkg::occupancy                occupancy_i,
	input  wire                                      iqFreeListReady_i,
	output logic                                     stall_o
);

	// number of valid loads and stores, up to DISPATCH_WIDTH each
	logic [`DISPATCH_WIDTH_LOG:0]    loadCnt;
	logic [`DISPATCH_WIDTH_LOG:0]    storeCnt;
	logic                            atomStall;
	// sums are one bit wider than the counters so they never wrap
	logic [`SIZE_LSQ_LOG+1:0]        ldqSum;
	logic [`SIZE_LSQ_LOG+1:0]        stqSum;
	logic [`SIZE_ISSUEQ_LOG+1:0]     iqSum;
	logic [`SIZE_ACTIVELIST_LOG+1:0] alSum;
	backEndPkg::stallCause           cause;

	always_comb
	begin
		int i;
		loadCnt   = '0;
		storeCnt  = '0;
		atomStall = 1'b0;
		// only valid lanes are counted, an invalid lane may carry stale flags
		for (i = 0; i < `DISPATCH_WIDTH; i++)
		begin
			loadCnt   = loadCnt + (bundle_i[i].valid & bundle_i[i].isLoad);
			storeCnt  = storeCnt + (bundle_i[i].valid & bundle_i[i].isStore);
			atomStall = atomStall | (bundle_i[i].valid & bundle_i[i].isAtom);
		end
	end

	assign ldqSum = occupancy_i.ldqCnt + loadCnt;
	assign stqSum = occupancy_i.stqCnt + storeCnt;
	assign iqSum  = occupancy_i.iqCnt + `DISPATCH_WIDTH;
	assign alSum  = occupancy_i.alCnt + `DISPATCH_WIDTH;

	// filling a structure exactly to its size is still allowed
	assign cause.ldqFull = ldqSum > `SIZE_LSQ;
	assign cause.stqFull = stqSum > `SIZE_LSQ;
	// the issue queue also waits on its free list being readable
	assign cause.iqFull  = (iqSum > `SIZE_ISSUEQ) | ~iqFreeListReady_i;
	assign cause.alFull  = alSum > `SIZE_ACTIVELIST;

	// holding the stage stalled through reset keeps every packet invalid
	assign stall_o = (|cause) | atomStall | ~rstN_i;

endmodule

`default_nettype wire

//--- dispatch.sv
// rename must hold its bundle unchanged while backEndFull_o is high, nothing is buffered here
`timescale 1ns/1ps
`default_nettype none

`include "dispatchDefines.svh"

module dispatch (
	input  wire                                                 clk,
	input  wire                                                 rstN_i,
	input  wire                                                 renameReady_i,
	input  wire                                                 iqFreeListReady_i,
	input  wire                                                 recoverFlag_i,
	input  wire dispatchPkg::disPkt [`DISPATCH_WIDTH-1:0]        disBundle_i,
	input  wire [`DISPATCH_WIDTH-1:0][`SIZE_ACTIVELIST_LOG-1:0] alID_i,
	input  wire [`DISPATCH_WIDTH-1:0][`SIZE_LSQ_LOG-1:0]        lsqID_i,
	input  wire backEndPkg::occupancy                           occupancy_i,
	output dispatchPkg::iqPkt  [`DISPATCH_WIDTH-1:0]            iqBundle_o,
	output dispatchPkg::alPkt  [`DISPATCH_WIDTH-1:0]            alBundle_o,
	output dispatchPkg::lsqPkt [`DISPATCH_WIDTH-1:0]            lsqBundle_o,
	output dispatchPkg::exceptionPkt                            excptPkt_o,
	output logic                                                dispatchReady_o,
	output logic                                                backEndFull_o
);

	// any back-end structure short of room, an atomic, or reset
	logic                                            stall;
	logic [`DISPATCH_WIDTH-1:0][`ISSUE_WIDTH_LOG-1:0] exePipes;
	logic [`DISPATCH_WIDTH-1:0]                      isSimple;

	backEndStallCheck stallCheck (
		.rstN_i            (rstN_i),
		.bundle_i          (disBundle_i),
		.occupancy_i       (occupancy_i),
		.iqFreeListReady_i (iqFreeListReady_i),
		.stall_o           (stall)
	);

	// the scheduler forms its own accept from renameReady and stall
	exePipeScheduler pipeSched (
		.clk           (clk),
		.rstN_i        (rstN_i),
		.recoverFlag_i (recoverFlag_i),
		.renameReady_i (renameReady_i),
		.stall_i       (stall),
		.bundle_i      (disBundle_i),
		.exePipes_o    (exePipes),
		.isSimple_o    (isSimple)
	);

	packetBuilder pktBuild (
		.bundle_i    (disBundle_i),
		.alID_i      (alID_i),
		.lsqID_i     (lsqID_i),
		.exePipes_i  (exePipes),
		.isSimple_i  (isSimple),
		.stall_i     (stall),
		.iqBundle_o  (iqBundle_o),
		.alBundle_o  (alBundle_o),
		.lsqBundle_o (lsqBundle_o)
	);

	exceptionSelect excptSel (
		.bundle_i   (disBundle_i),
		.alID_i     (alID_i),
		.stall_i    (stall),
		.excptPkt_o (excptPkt_o)
	);

	// bundle is taken by the back end in this cycle
	assign dispatchReady_o = renameReady_i & ~stall;
	// holds the instruction buffer and rename
	assign backEndFull_o   = stall;

endmodule

`default_nettype wire

//--- dispatchDefines.svh
// capacities are fixed at build time and every lane count, queue size and pipe number comes from here
`ifndef DISPATCH_DEFINES_SVH
`define DISPATCH_DEFINES_SVH

// lanes per rename bundle and the bits to count them
`define DISPATCH_WIDTH           4
`define DISPATCH_WIDTH_LOG       2

// execution pipes behind the issue queue
`define ISSUE_WIDTH              5
`define ISSUE_WIDTH_LOG          3

// fixed pipe numbers, two simple ALUs first and the control pipe last
`define SIMPLE_PIPE0             0
`define SIMPLE_PIPE1             1
`define COMPLEX_PIPE             2
`define MEMORY_PIPE              3
`define CONTROL_PIPE             (`ISSUE_WIDTH-1)

// back-end capacities, each counter is one bit wider than its index
`define SIZE_ISSUEQ              32
`define SIZE_ISSUEQ_LOG          5
`define SIZE_ACTIVELIST          64
`define SIZE_ACTIVELIST_LOG      6
// the load queue and the store queue each have this many entries
`define SIZE_LSQ                 16
`define SIZE_LSQ_LOG             4

// instruction payload widths
`define SIZE_PC                  32
`define SIZE_PHYSICAL_LOG        7
`define SIZE_RMT_LOG             5
`define SIZE_DATA                32
`define SIZE_EXCEPTION_CAUSE     4
`define SIZE_SEQNO               8

`endif

//--- dispatchPkg.sv
// packet layouts assume lane 0 is the oldest lane of a bundle and that rename already set every valid bit
`default_nettype none

`include "dispatchDefines.svh"

package dispatchPkg;

	// one renamed instruction as it leaves rename
	typedef struct packed {
		logic [`SIZE_SEQNO-1:0]           seqNo;
		logic [`SIZE_PC-1:0]              pc;
		backEndPkg::fuClass               fu;
		logic [`SIZE_RMT_LOG-1:0]         logDest;
		logic [`SIZE_PHYSICAL_LOG-1:0]    phyDest;
		logic                             phyDestValid;
		logic [`SIZE_PHYSICAL_LOG-1:0]    phySrc1;
		logic                             phySrc1Valid;
		logic [`SIZE_PHYSICAL_LOG-1:0]    phySrc2;
		logic                             phySrc2Valid;
		logic [`SIZE_DATA-1:0]            immed;
		logic                             immedValid;
		logic                             isLoad;
		logic                             isStore;
		// atomics are not handled by this back end and always stall
		logic                             isAtom;
		logic                             isCSR;
		logic [1:0]                       ldstSize;
		logic                             exception;
		logic [`SIZE_EXCEPTION_CAUSE-1:0] exceptionCause;
		logic                             valid;
	} disPkt;

	// issue-queue entry, fu now holds the pipe number and not the class
	typedef struct packed {
		logic [`SIZE_SEQNO-1:0]           seqNo;
		logic [`SIZE_PC-1:0]              pc;
		logic [`ISSUE_WIDTH_LOG-1:0]      fu;
		logic [`SIZE_PHYSICAL_LOG-1:0]    phyDest;
		logic                             phyDestValid;
		logic [`SIZE_PHYSICAL_LOG-1:0]    phySrc1;
		logic                             phySrc1Valid;
		logic [`SIZE_PHYSICAL_LOG-1:0]    phySrc2;
		logic                             phySrc2Valid;
		logic [`SIZE_DATA-1:0]            immed;
		logic                             immedValid;
		logic [`SIZE_ACTIVELIST_LOG-1:0]  alID;
		logic [`SIZE_LSQ_LOG-1:0]         lsqID;
		logic                             isLoad;
		logic                             isStore;
		logic                             isCSR;
		logic [1:0]                       ldstSize;
		logic                             isSimple;
		logic                             valid;
	} iqPkt;

	// active-list entry, written even for lanes that excepted
	typedef struct packed {
		logic [`SIZE_SEQNO-1:0]           seqNo;
		logic [`SIZE_PC-1:0]              pc;
		logic [`SIZE_RMT_LOG-1:0]         logDest;
		logic [`SIZE_PHYSICAL_LOG-1:0]    phyDest;
		logic                             phyDestValid;
		logic                             isLoad;
		logic                             isStore;
		logic                             isCSR;
		logic                             exception;
		logic [`SIZE_EXCEPTION_CAUSE-1:0] exceptionCause;
		logic                             valid;
	} alPkt;

	// load/store queue entry
	typedef struct packed {
		logic [`SIZE_SEQNO-1:0] seqNo;
		logic                   isLoad;
		logic                   isStore;
		logic                   valid;
	} lsqPkt;

	// oldest excepting instruction of the bundle
	typedef struct packed {
		logic [`SIZE_SEQNO-1:0]           seqNo;
		logic [`SIZE_ACTIVELIST_LOG-1:0]  alID;
		logic [`SIZE_EXCEPTION_CAUSE-1:0] exceptionCause;
		logic                             valid;
	} exceptionPkt;

endpackage

`default_nettype wire

//--- exceptionSelect.sv
// only the oldest excepting lane is reported, younger excepting lanes are left to the active list
`timescale 1ns/1ps
`default_nettype none

`include "dispatchDefines.svh"

module exceptionSelect (
	input  wire dispatchPkg::disPkt [`DISPATCH_WIDTH-1:0]        bundle_i,
	input  wire [`DISPATCH_WIDTH-1:0][`SIZE_ACTIVELIST_LOG-1:0] alID_i,
	input  wire                                                 stall_i,
	output dispatchPkg::exceptionPkt                            excptPkt_o
);

	logic [`DISPATCH_WIDTH-1:0]     excptVec;
	logic [`DISPATCH_WIDTH_LOG-1:0] excptLane;

	always_comb
	begin
		int i;
		excptLane = '0;
		for (i = 0; i < `DISPATCH_WIDTH; i++)
		begin
			excptVec[i] = bundle_i[i].valid & bundle_i[i].exception;
		end
		// walk from the youngest lane down so the oldest hit is written last
		for (i = `DISPATCH_WIDTH-1; i >= 0; i--)
		begin
			if (excptVec[i])
			begin
				excptLane = `DISPATCH_WIDTH_LOG'(i);
			end
		end
	end

	// with no hit the fields simply show lane 0
	assign excptPkt_o.seqNo          = bundle_i[excptLane].seqNo;
	assign excptPkt_o.alID           = alID_i[excptLane];
	assign excptPkt_o.exceptionCause = bundle_i[excptLane].exceptionCause;
	// a stalled bundle has no active-list entries yet, so nothing is reported
	assign excptPkt_o.valid          = (|excptVec) & ~stall_i;

endmodule

`default_nettype wire

//--- exePipeScheduler.sv
// simple ALU work is only balanced by alternation, the scheduler does not look at pipe occupancy
`timescale 1ns/1ps
`default_nettype none

`include "dispatchDefines.svh"

module exePipeScheduler (
	input  wire                                           clk,
	input  wire                                           rstN_i,
	input  wire                                           recoverFlag_i,
	input  wire                                           renameReady_i,
	input  wire                                           stall_i,
	input  wire dispatchPkg::disPkt [`DISPATCH_WIDTH-1:0] bundle_i,
	output logic [`DISPATCH_WIDTH-1:0][`ISSUE_WIDTH_LOG-1:0] exePipes_o,
	output logic [`DISPATCH_WIDTH-1:0]                    isSimple_o
);

	// picks the simple ALU for the first valid simple lane of the next bundle
	logic altSel;
	// value altSel takes once the current bundle is accepted
	logic altNext;
	logic accept;

	always_comb
	begin
		int i;
		logic turn;
		turn = altSel;
		for (i = 0; i < `DISPATCH_WIDTH; i++)
		begin
			exePipes_o[i] = `ISSUE_WIDTH_LOG'(`SIMPLE_PIPE0);
			isSimple_o[i] = 1'b0;
			// invalid lanes keep pipe 0 and do not consume a turn
			if (bundle_i[i].valid)
			begin
				case (bundle_i[i].fu)
					backEndPkg::fuSimple:
					begin
						isSimple_o[i] = 1'b1;
						exePipes_o[i] = turn ? `ISSUE_WIDTH_LOG'(`SIMPLE_PIPE1)
						                     : `ISSUE_WIDTH_LOG'(`SIMPLE_PIPE0);
						turn = ~turn;
					end
					backEndPkg::fuComplex: exePipes_o[i] = `ISSUE_WIDTH_LOG'(`COMPLEX_PIPE);
					backEndPkg::fuMemory:  exePipes_o[i] = `ISSUE_WIDTH_LOG'(`MEMORY_PIPE);
					default:               exePipes_o[i] = `ISSUE_WIDTH_LOG'(`CONTROL_PIPE);
				endcase
			end
		end
		// after the loop turn has flipped once per valid simple lane
		altNext = turn;
	end

	// same condition as dispatchReady at the top level
	assign accept = renameReady_i & ~stall_i;

	always_ff @(posedge clk)
	begin
		// recovery restarts at pipe 0 even if a bundle is accepted in that cycle
		if (!rstN_i || recoverFlag_i)
		begin
			altSel <= 1'b0;
		end
		else if (accept)
		begin
			altSel <= altNext;
		end
	end

endmodule

`default_nettype wire

//--- list.f
+incdir+.
backEndPkg.sv
dispatchPkg.sv
backEndStallCheck.sv
exePipeScheduler.sv
packetBuilder.sv
exceptionSelect.sv
dispatch.sv
tbDispatch.sv

//--- packetBuilder.sv
// packets carry their fields every cycle, only the valid bits say whether a queue may write them
`timescale 1ns/1ps
`default_nettype none

`include "dispatchDefines.svh"

module packetBuilder (
	input  wire dispatchPkg::disPkt [`DISPATCH_WIDTH-1:0]        bundle_i,
	input  wire [`DISPATCH_WIDTH-1:0][`SIZE_ACTIVELIST_LOG-1:0] alID_i,
	input  wire [`DISPATCH_WIDTH-1:0][`SIZE_LSQ_LOG-1:0]        lsqID_i,
	input  wire [`DISPATCH_WIDTH-1:0][`ISSUE_WIDTH_LOG-1:0]     exePipes_i,
	input  wire [`DISPATCH_WIDTH-1:0]                           isSimple_i,
	input  wire                                                 stall_i,
	output dispatchPkg::iqPkt  [`DISPATCH_WIDTH-1:0]            iqBundle_o,
	output dispatchPkg::alPkt  [`DISPATCH_WIDTH-1:0]            alBundle_o,
	output dispatchPkg::lsqPkt [`DISPATCH_WIDTH-1:0]            lsqBundle_o
);

	always_comb
	begin
		int i;
		for (i = 0; i < `DISPATCH_WIDTH; i++)
		begin
			// issue queue gets the pipe from the scheduler instead of the class
			iqBundle_o[i].seqNo        = bundle_i[i].seqNo;
			iqBundle_o[i].pc           = bundle_i[i].pc;
			iqBundle_o[i].fu           = exePipes_i[i];
			iqBundle_o[i].phyDest      = bundle_i[i].phyDest;
			iqBundle_o[i].phyDestValid = bundle_i[i].phyDestValid;
			iqBundle_o[i].phySrc1      = bundle_i[i].phySrc1;
			iqBundle_o[i].phySrc1Valid = bundle_i[i].phySrc1Valid;
			iqBundle_o[i].phySrc2      = bundle_i[i].phySrc2;
			iqBundle_o[i].phySrc2Valid = bundle_i[i].phySrc2Valid;
			iqBundle_o[i].immed        = bundle_i[i].immed;
			iqBundle_o[i].immedValid   = bundle_i[i].immedValid;
			iqBundle_o[i].alID         = alID_i[i];
			iqBundle_o[i].lsqID        = lsqID_i[i];
			iqBundle_o[i].isLoad       = bundle_i[i].isLoad;
			iqBundle_o[i].isStore      = bundle_i[i].isStore;
			iqBundle_o[i].isCSR        = bundle_i[i].isCSR;
			iqBundle_o[i].ldstSize     = bundle_i[i].ldstSize;
			iqBundle_o[i].isSimple     = isSimple_i[i];
			// an excepting instruction never issues
			iqBundle_o[i].valid = bundle_i[i].valid & ~stall_i & ~bundle_i[i].exception;

			alBundle_o[i].seqNo          = bundle_i[i].seqNo;
			alBundle_o[i].pc             = bundle_i[i].pc;
			alBundle_o[i].logDest        = bundle_i[i].logDest;
			alBundle_o[i].phyDest        = bundle_i[i].phyDest;
			alBundle_o[i].phyDestValid   = bundle_i[i].phyDestValid;
			alBundle_o[i].isLoad         = bundle_i[i].isLoad;
			alBundle_o[i].isStore        = bundle_i[i].isStore;
			alBundle_o[i].isCSR          = bundle_i[i].isCSR;
			alBundle_o[i].exception      = bundle_i[i].exception;
			alBundle_o[i].exceptionCause = bundle_i[i].exceptionCause;
			// the active list still needs the entry so commit can raise the exception in order
			alBundle_o[i].valid = bundle_i[i].valid & ~stall_i;

			lsqBundle_o[i].seqNo   = bundle_i[i].seqNo;
			lsqBundle_o[i].isLoad  = bundle_i[i].isLoad;
			lsqBundle_o[i].isStore = bundle_i[i].isStore;
			lsqBundle_o[i].valid   = bundle_i[i].valid & ~stall_i & ~bundle_i[i].exception;
		end
	end

endmodule

`default_nettype wire

//--- tbDispatch.sv
// needs a simulator with concurrent assertion support, random stimulus repeats from a fixed seed
`timescale 1ns/1ps
`default_nettype none

`include "dispatchDefines.svh"

module tbDispatch;

	localparam int NORMAL_VECTORS = 80;
	localparam int MIXED_VECTORS  = 200;
	// reset, first cycle after reset, boundaries and atomics add 8, 1, 17 and 8 vectors
	localparam int NUM_VECTORS    = 8 + 1 + NORMAL_VECTORS + 17 + 8 + MIXED_VECTORS;

	logic clk;
	logic rstN_i;
	logic renameReady_i;
	logic iqFreeListReady_i;
	logic recoverFlag_i;
	dispatchPkg::disPkt [`DISPATCH_WIDTH-1:0]              disBundle_i;
	logic [`DISPATCH_WIDTH-1:0][`SIZE_ACTIVELIST_LOG-1:0] alID_i;
	logic [`DISPATCH_WIDTH-1:0][`SIZE_LSQ_LOG-1:0]        lsqID_i;
	backEndPkg::occupancy                                 occupancy_i;
	dispatchPkg::iqPkt  [`DISPATCH_WIDTH-1:0]              iqBundle_o;
	dispatchPkg::alPkt  [`DISPATCH_WIDTH-1:0]              alBundle_o;
	dispatchPkg::lsqPkt [`DISPATCH_WIDTH-1:0]              lsqBundle_o;
	dispatchPkg::exceptionPkt                             excptPkt_o;
	logic dispatchReady_o;
	logic backEndFull_o;

	integer seed;
	int     errors;
	// model copy of the simple-ALU alternation bit
	logic   refAlt;
	logic   outValids;

	dispatch uut (
		.clk               (clk),
		.rstN_i            (rstN_i),
		.renameReady_i     (renameReady_i),
		.iqFreeListReady_i (iqFreeListReady_i),
		.recoverFlag_i     (recoverFlag_i),
		.disBundle_i       (disBundle_i),
		.alID_i            (alID_i),
		.lsqID_i           (lsqID_i),
		.occupancy_i       (occupancy_i),
		.iqBundle_o        (iqBundle_o),
		.alBundle_o        (alBundle_o),
		.lsqBundle_o       (lsqBundle_o),
		.excptPkt_o        (excptPkt_o),
		.dispatchReady_o   (dispatchReady_o),
		.backEndFull_o     (backEndFull_o)
	);

	initial
	begin
		clk = 1'b0;
		forever
		begin
			#5 clk = ~clk;
		end
	end

	task automatic reportMismatch(input string msg);
		$display("[FAIL] %0t ns: %s", $time, msg);
		errors++;
	endtask

	function automatic int randBelow(input int n);
		int r;
		r = $random(seed);
		return (r & 32'h7fff_ffff) % n;
	endfunction

	// the IQ and AL need room for a full bundle whatever the number of valid lanes
	function automatic logic expectStall();
		int   i;
		int   loads;
		int   stores;
		logic atom;
		loads  = 0;
		stores = 0;
		atom   = 1'b0;
		for (i = 0; i < `DISPATCH_WIDTH; i++)
		begin
			if (disBundle_i[i].valid)
			begin
				loads  += disBundle_i[i].isLoad;
				stores += disBundle_i[i].isStore;
				atom   |= disBundle_i[i].isAtom;
			end
		end
		return !rstN_i || !iqFreeListReady_i || atom
			|| int'(occupancy_i.iqCnt) + `DISPATCH_WIDTH > `SIZE_ISSUEQ
			|| int'(occupancy_i.alCnt) + `DISPATCH_WIDTH > `SIZE_ACTIVELIST
			|| int'(occupancy_i.ldqCnt) + loads > `SIZE_LSQ
			|| int'(occupancy_i.stqCnt) + stores > `SIZE_LSQ;
	endfunction

	function automatic logic simpleParity();
		logic p;
		int   i;
		p = 1'b0;
		for (i = 0; i < `DISPATCH_WIDTH; i++)
		begin
			p ^= disBundle_i[i].valid && disBundle_i[i].fu == backEndPkg::fuSimple;
		end
		return p;
	endfunction

	// the model bit moves on the same edge as the DUT, recovery wins over an accepted bundle
	always @(posedge clk)
	begin
		if (!rstN_i || recoverFlag_i)
		begin
			refAlt <= 1'b0;
		end
		else if (renameReady_i && !expectStall())
		begin
			refAlt <= refAlt ^ simpleParity();
		end
	end

	// one lane can be invalid, excepting or atomic with the given odds
	task automatic fillBundle(input int excptOneIn, input int atomOneIn);
		logic [127:0] raw;
		int           r;
		int           i;
		for (i = 0; i < `DISPATCH_WIDTH; i++)
		begin
			raw = {$random(seed), $random(seed), $random(seed), $random(seed)};
			disBundle_i[i]           = raw[$bits(dispatchPkg::disPkt)-1:0];
			disBundle_i[i].valid     = randBelow(8) != 0;
			disBundle_i[i].exception = excptOneIn != 0 && randBelow(excptOneIn) == 0;
			disBundle_i[i].isAtom    = atomOneIn != 0 && randBelow(atomOneIn) == 0;
			r          = $random(seed);
			alID_i[i]  = r[`SIZE_ACTIVELIST_LOG-1:0];
			lsqID_i[i] = r[`SIZE_ACTIVELIST_LOG+`SIZE_LSQ_LOG-1:`SIZE_ACTIVELIST_LOG];
		end
	endtask

	task automatic setOccupancy(input int iq, input int al, input int ldq, input int stq);
		occupancy_i.iqCnt  = iq[`SIZE_ISSUEQ_LOG:0];
		occupancy_i.alCnt  = al[`SIZE_ACTIVELIST_LOG:0];
		occupancy_i.ldqCnt = ldq[`SIZE_LSQ_LOG:0];
		occupancy_i.stqCnt = stq[`SIZE_LSQ_LOG:0];
	endtask

	task automatic stepCycle();
		@(posedge clk);
		#1;
	endtask

	// compares every output against the model at each falling edge
	task automatic checkOutputs();
		dispatchPkg::disPkt          d;
		dispatchPkg::iqPkt           expIq;
		dispatchPkg::alPkt           expAl;
		dispatchPkg::lsqPkt          expLsq;
		dispatchPkg::exceptionPkt    expExc;
		logic [`ISSUE_WIDTH_LOG-1:0] pipe;
		logic                        stall;
		int                          simpleSeen;
		int                          i;
		int                          lane;
		int                          sel;
		stall      = expectStall();
		simpleSeen = 0;
		lane       = -1;
		assert (backEndFull_o === stall && dispatchReady_o === (renameReady_i && !stall))
		else reportMismatch($sformatf("ready=%b full=%b", dispatchReady_o, backEndFull_o));
		for (i = 0; i < `DISPATCH_WIDTH; i++)
		begin
			d    = disBundle_i[i];
			pipe = `ISSUE_WIDTH_LOG'(`SIMPLE_PIPE0);
			if (d.valid && d.fu == backEndPkg::fuSimple)
			begin
				// valid simple lanes alternate, starting from the pipe held in the model bit
				pipe = `ISSUE_WIDTH_LOG'((simpleSeen + int'(refAlt)) % 2);
				simpleSeen++;
			end
			else if (d.valid)
			begin
				// complex, memory and control follow simple in pipe order 2, 3 and 4
				pipe = `ISSUE_WIDTH_LOG'(int'(d.fu) + 1);
			end
			if (lane < 0 && d.valid && d.exception)
			begin
				lane = i;
			end
			expIq = '{seqNo: d.seqNo, pc: d.pc, fu: pipe, phyDest: d.phyDest,
				phyDestValid: d.phyDestValid, phySrc1: d.phySrc1, phySrc1Valid: d.phySrc1Valid,
				phySrc2: d.phySrc2, phySrc2Valid: d.phySrc2Valid, immed: d.immed,
				immedValid: d.immedValid, alID: alID_i[i], lsqID: lsqID_i[i],
				isLoad: d.isLoad, isStore: d.isStore, isCSR: d.isCSR, ldstSize: d.ldstSize,
				isSimple: d.valid && d.fu == backEndPkg::fuSimple,
				valid: d.valid && !stall && !d.exception};
			// excepting lanes still enter the active list
			expAl = '{seqNo: d.seqNo, pc: d.pc, logDest: d.logDest, phyDest: d.phyDest,
				phyDestValid: d.phyDestValid, isLoad: d.isLoad, isStore: d.isStore,
				isCSR: d.isCSR, exception: d.exception, exceptionCause: d.exceptionCause,
				valid: d.valid && !stall};
			expLsq = '{seqNo: d.seqNo, isLoad: d.isLoad, isStore: d.isStore,
				valid: d.valid && !stall && !d.exception};
			assert (iqBundle_o[i] === expIq)
			else reportMismatch($sformatf("lane %0d issue-queue packet, pipe %0d", i, pipe));
			assert (alBundle_o[i] === expAl)
			else reportMismatch($sformatf("lane %0d active-list packet", i));
			assert (lsqBundle_o[i] === expLsq)
			else reportMismatch($sformatf("lane %0d load/store packet", i));
		end
		sel    = lane < 0 ? 0 : lane;
		expExc = '{seqNo: disBundle_i[sel].seqNo, alID: alID_i[sel],
			exceptionCause: disBundle_i[sel].exceptionCause, valid: lane >= 0 && !stall};
		assert (excptPkt_o === expExc)
		else reportMismatch($sformatf("exception packet, expected lane %0d", lane));
	endtask

	always @(negedge clk)
	begin
		checkOutputs();
	end

	always_comb
	begin
		outValids = excptPkt_o.valid;
		for (int i = 0; i < `DISPATCH_WIDTH; i++)
		begin
			outValids = outValids | iqBundle_o[i].valid | alBundle_o[i].valid
				| lsqBundle_o[i].valid;
		end
	end

	assert property (@(posedge clk) backEndFull_o |-> !outValids)
	else reportMismatch("packet valid while the back end is full");

	// queue 0 to 3 is IQ, AL, load queue, store queue, over 1 puts it one past the limit
	task automatic boundaryCase(input int queue, input logic useStores, input int over);
		int i;
		int lim;
		stepCycle();
		fillBundle(0, 0);
		for (i = 0; i < `DISPATCH_WIDTH; i++)
		begin
			disBundle_i[i].valid   = 1'b1;
			disBundle_i[i].isLoad  = !useStores;
			disBundle_i[i].isStore = useStores;
		end
		lim = ((queue == 2 && !useStores) || (queue == 3 && useStores))
			? `SIZE_LSQ - `DISPATCH_WIDTH : `SIZE_LSQ;
		setOccupancy(queue == 0 ? `SIZE_ISSUEQ - `DISPATCH_WIDTH + over : 0,
			queue == 1 ? `SIZE_ACTIVELIST - `DISPATCH_WIDTH + over : 0,
			queue == 2 ? lim + over : 0, queue == 3 ? lim + over : 0);
		#2;
		assert (backEndFull_o === (over != 0))
		else reportMismatch($sformatf("queue %0d boundary with over=%0d", queue, over));
	endtask

	initial
	begin
		int k;
		seed              = 32'h1aa0_13c9;
		errors            = 0;
		rstN_i            = 1'b0;
		renameReady_i     = 1'b1;
		iqFreeListReady_i = 1'b1;
		recoverFlag_i     = 1'b0;
		fillBundle(4, 0);
		setOccupancy(0, 0, 0, 0);
		for (k = 0; k < 8; k++)
		begin
			stepCycle();
			if (k == 7)
			begin
				rstN_i            = 1'b1;
				iqFreeListReady_i = 1'b0;
			end
			fillBundle(4, 0);
			#2;
			assert (backEndFull_o === 1'b1 && dispatchReady_o === 1'b0)
			else reportMismatch("stage not stalled in or right after reset");
		end
		// small occupancy and no atomics, so bundles flow through
		for (k = 0; k < NORMAL_VECTORS; k++)
		begin
			stepCycle();
			fillBundle(4, 0);
			setOccupancy(randBelow(20), randBelow(50), randBelow(8), randBelow(8));
			renameReady_i     = randBelow(8) != 0;
			iqFreeListReady_i = 1'b1;
			recoverFlag_i     = randBelow(20) == 0;
		end
		recoverFlag_i = 1'b0;
		renameReady_i = 1'b1;
		for (k = 0; k < 16; k++)
		begin
			boundaryCase(k / 4, k[1], k % 2);
		end
		stepCycle();
		setOccupancy(0, 0, 0, 0);
		iqFreeListReady_i = 1'b0;
		#2;
		assert (backEndFull_o === 1'b1)
		else reportMismatch("no stall with the issue free list not ready");
		iqFreeListReady_i = 1'b1;
		// one atomic lane that is valid on even steps only
		for (k = 0; k < 8; k++)
		begin
			stepCycle();
			fillBundle(0, 0);
			disBundle_i[k % `DISPATCH_WIDTH].isAtom = 1'b1;
			disBundle_i[k % `DISPATCH_WIDTH].valid  = k % 2 == 0;
			#2;
			assert (backEndFull_o === (k % 2 == 0))
			else reportMismatch($sformatf("atomic in lane %0d handled wrongly", k % 4));
		end
		// occupancy near the limits gives a mix of accepted and stalled bundles
		for (k = 0; k < MIXED_VECTORS; k++)
		begin
			stepCycle();
			fillBundle(4, 12);
			setOccupancy(26 + randBelow(4), 58 + randBelow(4), 10 + randBelow(6),
				10 + randBelow(6));
			renameReady_i     = randBelow(8) != 0;
			iqFreeListReady_i = randBelow(16) != 0;
			recoverFlag_i     = randBelow(16) == 0;
		end
		@(negedge clk);
		#1;
		$display("closing: %0d errors over %0d vectors", errors, NUM_VECTORS);
		if (errors == 0)
		begin
			$display("Testbench passed");
		end
		else
		begin
			$display("Testbench failed");
		end
		$finish;
	end

	// twice the nominal run length
	initial
	begin
		#(NUM_VECTORS * 10 * 2);
		$display("the run timed out after %0d ns without finishing", NUM_VECTORS * 20);
		$display("Testbench failed");
		$finish;
	end

endmodule

`default_nettype wire
